/* include/axi_lite_config.svh */
/*
 * Bus widths and memory depth shared by the AXI-lite memory subsystem.
 * Include wherever a width or the SRAM size is needed.
 */
`ifndef AXI_LITE_CONFIG_SVH
`define AXI_LITE_CONFIG_SVH

`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
// one strobe per data byte
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)
// 64 words, byte addresses 0 to 255
`define MEM_WORDS 64

`endif

/* src/axi_lite_pkg.sv */
/*
 * AXI-lite protocol types: response codes and the arbiter's grant encodings.
 */
package axi_lite_pkg;

    // only the two codes this subsystem produces
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // current holder of the shared bus
    typedef enum logic [1:0] {
        NONE = 2'b00,
        IFU  = 2'b01,
        LSU  = 2'b10
    } bus_owner_t;

    // transaction kind of the current owner
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } xfer_kind_t;

endpackage

/* src/mem_map_pkg.sv */
/*
 * Memory map types: address decode result and SRAM row index.
 */
`include "axi_lite_config.svh"

package mem_map_pkg;

    // anything past the SRAM is unmapped
    typedef enum logic {
        RAM      = 1'b0,
        UNMAPPED = 1'b1
    } mem_region_t;

    typedef logic [$clog2(`MEM_WORDS)-1:0] word_index_t;

endpackage

/* src/axi_lite_if.sv */
/*
 * AXI-lite bus with all five channels, no prot, single outstanding transfer.
 * Managers connect through the manager modport, memories through subordinate.
 */
`timescale 1ns/1ps
`include "axi_lite_config.svh"

interface axi_lite_if
    import axi_lite_pkg::*;
();

    // read address
    logic                       ar_valid;
    logic                       ar_ready;
    logic [`AXI_ADDR_WIDTH-1:0] ar_addr;

    // write address
    logic                       aw_valid;
    logic                       aw_ready;
    logic [`AXI_ADDR_WIDTH-1:0] aw_addr;

    // write data
    logic                       w_valid;
    logic                       w_ready;
    logic [`AXI_DATA_WIDTH-1:0] w_data;
    logic [`AXI_STRB_WIDTH-1:0] w_strb;

    // write response
    logic                       b_valid;
    logic                       b_ready;
    axi_resp_t                  b_resp;

    // read data
    logic                       r_valid;
    logic                       r_ready;
    logic [`AXI_DATA_WIDTH-1:0] r_data;
    axi_resp_t                  r_resp;

    modport manager (
        output ar_valid, ar_addr, aw_valid, aw_addr, w_valid, w_data, w_strb,
        output b_ready, r_ready,
        input  ar_ready, aw_ready, w_ready, b_valid, b_resp, r_valid, r_data, r_resp
    );

    modport subordinate (
        input  ar_valid, ar_addr, aw_valid, aw_addr, w_valid, w_data, w_strb,
        input  b_ready, r_ready,
        output ar_ready, aw_ready, w_ready, b_valid, b_resp, r_valid, r_data, r_resp
    );

endinterface

/* src/axi_lite_arbiter.sv */
/*
 * Fixed-priority arbiter for two AXI-lite managers onto one subordinate.
 * The lsu wins ties; a grant is held until the read or write response completes.
 */
`timescale 1ns/1ps

module axi_lite_arbiter
    import axi_lite_pkg::*;
(
    input logic               clk,
    input logic               reset,
    axi_lite_if.subordinate   ifu,
    axi_lite_if.subordinate   lsu,
    axi_lite_if.manager       mem
);

    bus_owner_t owner;
    xfer_kind_t kind;

    logic ifu_rd_req;
    logic ifu_wr_req;
    logic lsu_rd_req;
    logic lsu_wr_req;
    logic own_ifu;
    logic own_lsu;
    logic is_read;
    logic is_write;
    logic rsp_done;

    // a write needs address and data together
    assign ifu_rd_req = ifu.ar_valid;
    assign ifu_wr_req = ifu.aw_valid & ifu.w_valid;
    assign lsu_rd_req = lsu.ar_valid;
    assign lsu_wr_req = lsu.aw_valid & lsu.w_valid;

    assign own_ifu  = (owner == IFU);
    assign own_lsu  = (owner == LSU);
    assign is_read  = (kind == READ);
    assign is_write = (kind == WRITE);

    assign rsp_done = (mem.r_valid & mem.r_ready) | (mem.b_valid & mem.b_ready);

    // grant register, free when owner is NONE
    always_ff @(posedge clk) begin
        if (!reset) begin
            owner <= NONE;
            kind  <= READ;
        end else if (owner == NONE) begin
            if (lsu_rd_req || lsu_wr_req) begin
                owner <= LSU;
                kind  <= lsu_rd_req ? READ : WRITE;
            end else if (ifu_rd_req || ifu_wr_req) begin
                owner <= IFU;
                kind  <= ifu_rd_req ? READ : WRITE;
            end
        end else if (rsp_done) begin
            owner <= NONE;
        end
    end

    // request channels, only those of the granted kind
    assign mem.ar_valid = is_read & (own_lsu ? lsu.ar_valid : own_ifu & ifu.ar_valid);
    assign mem.ar_addr  = own_lsu ? lsu.ar_addr : ifu.ar_addr;

    assign mem.aw_valid = is_write & (own_lsu ? lsu.aw_valid : own_ifu & ifu.aw_valid);
    assign mem.aw_addr  = own_lsu ? lsu.aw_addr : ifu.aw_addr;

    assign mem.w_valid  = is_write & (own_lsu ? lsu.w_valid : own_ifu & ifu.w_valid);
    assign mem.w_data   = own_lsu ? lsu.w_data : ifu.w_data;
    assign mem.w_strb   = own_lsu ? lsu.w_strb : ifu.w_strb;

    // readys go back to the owner alone
    assign ifu.ar_ready = own_ifu & is_read & mem.ar_ready;
    assign lsu.ar_ready = own_lsu & is_read & mem.ar_ready;
    assign ifu.aw_ready = own_ifu & is_write & mem.aw_ready;
    assign lsu.aw_ready = own_lsu & is_write & mem.aw_ready;
    assign ifu.w_ready  = own_ifu & is_write & mem.w_ready;
    assign lsu.w_ready  = own_lsu & is_write & mem.w_ready;

    // response valids gated by the registered grant
    assign ifu.r_valid = own_ifu & is_read & mem.r_valid;
    assign lsu.r_valid = own_lsu & is_read & mem.r_valid;
    assign ifu.b_valid = own_ifu & is_write & mem.b_valid;
    assign lsu.b_valid = own_lsu & is_write & mem.b_valid;

    // payloads are only meaningful with valid
    assign ifu.r_data = mem.r_data;
    assign lsu.r_data = mem.r_data;
    assign ifu.r_resp = mem.r_resp;
    assign lsu.r_resp = mem.r_resp;
    assign ifu.b_resp = mem.b_resp;
    assign lsu.b_resp = mem.b_resp;

    assign mem.r_ready = is_read & (own_lsu ? lsu.r_ready : own_ifu & ifu.r_ready);
    assign mem.b_ready = is_write & (own_lsu ? lsu.b_ready : own_ifu & ifu.b_ready);

endmodule

/* src/axi_lite_sram.sv */
/*
 * Word-addressed SRAM behind an AXI-lite subordinate port.
 * Writes honour byte strobes; addresses past the array answer SLVERR.
 */
`timescale 1ns/1ps
`include "axi_lite_config.svh"

module axi_lite_sram
    import axi_lite_pkg::*;
    import mem_map_pkg::*;
(
    input logic               clk,
    input logic               reset,
    axi_lite_if.subordinate   bus
);

    localparam int IDX_LSB = $clog2(`AXI_STRB_WIDTH);
    localparam logic [`AXI_ADDR_WIDTH-1:0] MEM_BYTES = `MEM_WORDS * `AXI_STRB_WIDTH;

    logic [`AXI_DATA_WIDTH-1:0] ram [`MEM_WORDS];

    logic                       rd_pend;
    logic                       wr_pend;
    logic [`AXI_DATA_WIDTH-1:0] rsp_data;
    axi_resp_t                  rsp_code;

    logic        idle;
    logic        rd_fire;
    logic        wr_fire;
    mem_region_t rd_region;
    mem_region_t wr_region;
    word_index_t rd_idx;
    word_index_t wr_idx;

    function automatic mem_region_t decode(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        return (addr < MEM_BYTES) ? RAM : UNMAPPED;
    endfunction

    function automatic word_index_t to_index(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        return addr[IDX_LSB +: $bits(word_index_t)];
    endfunction

    assign rd_region = decode(bus.ar_addr);
    assign wr_region = decode(bus.aw_addr);
    assign rd_idx    = to_index(bus.ar_addr);
    assign wr_idx    = to_index(bus.aw_addr);

    // one transaction at a time, reads first
    assign idle         = !rd_pend && !wr_pend;
    assign bus.ar_ready = idle;
    assign bus.aw_ready = idle && bus.aw_valid && bus.w_valid && !bus.ar_valid;
    assign bus.w_ready  = bus.aw_ready;

    assign rd_fire = bus.ar_valid & bus.ar_ready;
    assign wr_fire = bus.aw_valid & bus.aw_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
        end else begin
            if (rd_fire) begin
                rd_pend <= 1'b1;
            end else if (bus.r_valid && bus.r_ready) begin
                rd_pend <= 1'b0;
            end
            if (wr_fire) begin
                wr_pend <= 1'b1;
            end else if (bus.b_valid && bus.b_ready) begin
                wr_pend <= 1'b0;
            end
        end
    end

    // strobed byte writes, unmapped writes are dropped
    always_ff @(posedge clk) begin
        if (wr_fire && wr_region == RAM) begin
            for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
                if (bus.w_strb[i]) begin
                    ram[wr_idx][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    // response captured at the request, held until the handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data <= (rd_region == RAM) ? ram[rd_idx] : '0;
            rsp_code <= (rd_region == RAM) ? OKAY : SLVERR;
        end else if (wr_fire) begin
            rsp_code <= (wr_region == RAM) ? OKAY : SLVERR;
        end
    end

    assign bus.r_valid = rd_pend;
    assign bus.r_data  = rsp_data;
    assign bus.r_resp  = rsp_code;
    assign bus.b_valid = wr_pend;
    assign bus.b_resp  = rsp_code;

endmodule

/* src/mem_subsystem.sv */
/*
 * Top level: ifu and lsu AXI-lite ports share one SRAM through the arbiter.
 */
`timescale 1ns/1ps
`include "axi_lite_config.svh"

module mem_subsystem (
    input  logic                       clk,
    input  logic                       reset,
    // instruction fetch
    input  logic                       ifu_ar_valid,
    output logic                       ifu_ar_ready,
    input  logic [`AXI_ADDR_WIDTH-1:0] ifu_ar_addr,
    input  logic                       ifu_aw_valid,
    output logic                       ifu_aw_ready,
    input  logic [`AXI_ADDR_WIDTH-1:0] ifu_aw_addr,
    input  logic                       ifu_w_valid,
    output logic                       ifu_w_ready,
    input  logic [`AXI_DATA_WIDTH-1:0] ifu_w_data,
    input  logic [`AXI_STRB_WIDTH-1:0] ifu_w_strb,
    output logic                       ifu_b_valid,
    input  logic                       ifu_b_ready,
    output logic [1:0]                 ifu_b_resp,
    output logic                       ifu_r_valid,
    input  logic                       ifu_r_ready,
    output logic [`AXI_DATA_WIDTH-1:0] ifu_r_data,
    output logic [1:0]                 ifu_r_resp,
    // load/store
    input  logic                       lsu_ar_valid,
    output logic                       lsu_ar_ready,
    input  logic [`AXI_ADDR_WIDTH-1:0] lsu_ar_addr,
    input  logic                       lsu_aw_valid,
    output logic                       lsu_aw_ready,
    input  logic [`AXI_ADDR_WIDTH-1:0] lsu_aw_addr,
    input  logic                       lsu_w_valid,
    output logic                       lsu_w_ready,
    input  logic [`AXI_DATA_WIDTH-1:0] lsu_w_data,
    input  logic [`AXI_STRB_WIDTH-1:0] lsu_w_strb,
    output logic                       lsu_b_valid,
    input  logic                       lsu_b_ready,
    output logic [1:0]                 lsu_b_resp,
    output logic                       lsu_r_valid,
    input  logic                       lsu_r_ready,
    output logic [`AXI_DATA_WIDTH-1:0] lsu_r_data,
    output logic [1:0]                 lsu_r_resp
);

    axi_lite_if ifu_bus ();
    axi_lite_if lsu_bus ();
    axi_lite_if mem_bus ();

    // ifu side
    assign ifu_bus.ar_valid = ifu_ar_valid;
    assign ifu_bus.ar_addr  = ifu_ar_addr;
    assign ifu_bus.aw_valid = ifu_aw_valid;
    assign ifu_bus.aw_addr  = ifu_aw_addr;
    assign ifu_bus.w_valid  = ifu_w_valid;
    assign ifu_bus.w_data   = ifu_w_data;
    assign ifu_bus.w_strb   = ifu_w_strb;
    assign ifu_bus.b_ready  = ifu_b_ready;
    assign ifu_bus.r_ready  = ifu_r_ready;
    assign ifu_ar_ready     = ifu_bus.ar_ready;
    assign ifu_aw_ready     = ifu_bus.aw_ready;
    assign ifu_w_ready      = ifu_bus.w_ready;
    assign ifu_b_valid      = ifu_bus.b_valid;
    assign ifu_b_resp       = ifu_bus.b_resp;
    assign ifu_r_valid      = ifu_bus.r_valid;
    assign ifu_r_data       = ifu_bus.r_data;
    assign ifu_r_resp       = ifu_bus.r_resp;

    // lsu side
    assign lsu_bus.ar_valid = lsu_ar_valid;
    assign lsu_bus.ar_addr  = lsu_ar_addr;
    assign lsu_bus.aw_valid = lsu_aw_valid;
    assign lsu_bus.aw_addr  = lsu_aw_addr;
    assign lsu_bus.w_valid  = lsu_w_valid;
    assign lsu_bus.w_data   = lsu_w_data;
    assign lsu_bus.w_strb   = lsu_w_strb;
    assign lsu_bus.b_ready  = lsu_b_ready;
    assign lsu_bus.r_ready  = lsu_r_ready;
    assign lsu_ar_ready     = lsu_bus.ar_ready;
    assign lsu_aw_ready     = lsu_bus.aw_ready;
    assign lsu_w_ready      = lsu_bus.w_ready;
    assign lsu_b_valid      = lsu_bus.b_valid;
    assign lsu_b_resp       = lsu_bus.b_resp;
    assign lsu_r_valid      = lsu_bus.r_valid;
    assign lsu_r_data       = lsu_bus.r_data;
    assign lsu_r_resp       = lsu_bus.r_resp;

    axi_lite_arbiter arb0 (
        .clk   (clk),
        .reset (reset),
        .ifu   (ifu_bus.subordinate),
        .lsu   (lsu_bus.subordinate),
        .mem   (mem_bus.manager)
    );

    axi_lite_sram sram0 (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus.subordinate)
    );

endmodule

/* verif/mem_subsystem_tb.sv */
/*
 * Testbench for the memory subsystem. Replays verif/mem_patterns.txt on the ifu and lsu
 * ports with random response back-pressure and checks every response and its ordering.
 */
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int NUM_LINES   = 15;
    localparam int FIELDS      = 8;
    localparam int CYCLE_LIMIT = 40 * NUM_LINES;

    logic clk;
    logic reset;

    // index 0 is the ifu and index 1 the lsu
    logic [1:0]       ar_valid;
    logic [1:0]       ar_ready;
    logic [1:0][31:0] ar_addr;
    logic [1:0]       aw_valid;
    logic [1:0]       aw_ready;
    logic [1:0][31:0] aw_addr;
    logic [1:0]       w_valid;
    logic [1:0]       w_ready;
    logic [1:0][31:0] w_data;
    logic [1:0][3:0]  w_strb;
    logic [1:0]       b_valid;
    logic [1:0]       b_ready;
    logic [1:0][1:0]  b_resp;
    logic [1:0]       r_valid;
    logic [1:0]       r_ready;
    logic [1:0][31:0] r_data;
    logic [1:0][1:0]  r_resp;

    // group, manager, op, addr, wdata, strb, rdata, resp for each line
    logic [31:0] pat [FIELDS*NUM_LINES];
    logic [31:0] grp;
    integer      seed;
    int          cycles;
    logic        lsu_busy;
    int          i;
    int          j;

    mem_subsystem dut0 (
        .clk          (clk),
        .reset        (reset),
        .ifu_ar_valid (ar_valid[0]), .lsu_ar_valid (ar_valid[1]),
        .ifu_ar_ready (ar_ready[0]), .lsu_ar_ready (ar_ready[1]),
        .ifu_ar_addr  (ar_addr[0]),  .lsu_ar_addr  (ar_addr[1]),
        .ifu_aw_valid (aw_valid[0]), .lsu_aw_valid (aw_valid[1]),
        .ifu_aw_ready (aw_ready[0]), .lsu_aw_ready (aw_ready[1]),
        .ifu_aw_addr  (aw_addr[0]),  .lsu_aw_addr  (aw_addr[1]),
        .ifu_w_valid  (w_valid[0]),  .lsu_w_valid  (w_valid[1]),
        .ifu_w_ready  (w_ready[0]),  .lsu_w_ready  (w_ready[1]),
        .ifu_w_data   (w_data[0]),   .lsu_w_data   (w_data[1]),
        .ifu_w_strb   (w_strb[0]),   .lsu_w_strb   (w_strb[1]),
        .ifu_b_valid  (b_valid[0]),  .lsu_b_valid  (b_valid[1]),
        .ifu_b_ready  (b_ready[0]),  .lsu_b_ready  (b_ready[1]),
        .ifu_b_resp   (b_resp[0]),   .lsu_b_resp   (b_resp[1]),
        .ifu_r_valid  (r_valid[0]),  .lsu_r_valid  (r_valid[1]),
        .ifu_r_ready  (r_ready[0]),  .lsu_r_ready  (r_ready[1]),
        .ifu_r_data   (r_data[0]),   .lsu_r_data   (r_data[1]),
        .ifu_r_resp   (r_resp[0]),   .lsu_r_resp   (r_resp[1])
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // runs one pattern line as a request and then a response
    task automatic run_xfer(input int line);
        int          m;
        logic        rd;
        string       pfx;
        string       dname;
        string       rname;
        logic [31:0] exp_data;
        logic [31:0] exp_resp;
        logic [31:0] data_now;
        logic [31:0] resp_now;
        logic [31:0] data_held;
        logic [31:0] resp_held;
        logic        seen;
        logic        valid_now;
        logic        fire;
        logic        ar_hit;
        logic        aw_hit;
        logic        w_hit;

        m        = int'(pat[line*FIELDS+1]);
        rd       = (pat[line*FIELDS+2] == 32'd0);
        pfx      = (m == 0) ? "ifu" : "lsu";
        dname    = {pfx, "_r_data"};
        rname    = rd ? {pfx, "_r_resp"} : {pfx, "_b_resp"};
        exp_data = pat[line*FIELDS+6];
        exp_resp = pat[line*FIELDS+7];

        if (rd) begin
            ar_addr[m]  = pat[line*FIELDS+3];
            ar_valid[m] = 1'b1;
        end else begin
            aw_addr[m]  = pat[line*FIELDS+3];
            w_data[m]   = pat[line*FIELDS+4];
            w_strb[m]   = pat[line*FIELDS+5][3:0];
            aw_valid[m] = 1'b1;
            w_valid[m]  = 1'b1;
        end

        // each valid drops after its own transfer
        do begin
            @(negedge clk);
            ar_hit = ar_valid[m] && ar_ready[m];
            aw_hit = aw_valid[m] && aw_ready[m];
            w_hit  = w_valid[m] && w_ready[m];
            @(posedge clk);
            #2;
            if (ar_hit) ar_valid[m] = 1'b0;
            if (aw_hit) aw_valid[m] = 1'b0;
            if (w_hit) w_valid[m] = 1'b0;
        end while (ar_valid[m] || aw_valid[m] || w_valid[m]);

        seen      = 1'b0;
        data_held = '0;
        resp_held = '0;
        do begin
            // ready low about one cycle in four
            if (rd) begin
                r_ready[m] = (($random(seed) & 3) != 0);
            end else begin
                b_ready[m] = (($random(seed) & 3) != 0);
            end
            @(negedge clk);
            valid_now = rd ? r_valid[m] : b_valid[m];
            fire      = valid_now && (rd ? r_ready[m] : b_ready[m]);
            data_now  = rd ? r_data[m] : 32'h0;
            resp_now  = 32'(rd ? r_resp[m] : b_resp[m]);
            if (valid_now) begin
                if (seen) begin
                    if (rd) begin
                        check_value(dname, data_now, data_held);
                    end
                    check_value(rname, resp_now, resp_held);
                end else if (m == 0) begin
                    check_value("lsu_busy at ifu response", 32'(lsu_busy), 32'h0);
                end
                seen      = 1'b1;
                data_held = data_now;
                resp_held = resp_now;
            end
            if (fire && m == 1) begin
                lsu_busy = 1'b0;
            end
            @(posedge clk);
            #2;
        end while (!fire);
        r_ready[m] = 1'b0;
        b_ready[m] = 1'b0;

        if (rd) begin
            check_value(dname, data_now, exp_data);
        end
        check_value(rname, resp_now, exp_resp);
    endtask

    // a held response keeps the other manager out
    always @(negedge clk) begin
        if (reset) begin
            if (r_valid[1] || b_valid[1]) begin
                check_value("ifu request readys", 32'({ar_ready[0], aw_ready[0], w_ready[0]}),
                            32'h0);
            end
            if (r_valid[0] || b_valid[0]) begin
                check_value("lsu request readys", 32'({ar_ready[1], aw_ready[1], w_ready[1]}),
                            32'h0);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the patterns did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b0;
        ar_valid = '0;
        ar_addr  = '0;
        aw_valid = '0;
        aw_addr  = '0;
        w_valid  = '0;
        w_data   = '0;
        w_strb   = '0;
        b_ready  = '0;
        r_ready  = '0;
        seed     = 32'h871cbc98;
        cycles   = 0;
        lsu_busy = 1'b0;
        $readmemh("verif/mem_patterns.txt", pat);

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b1;

        // nothing granted and nothing pending out of reset
        @(negedge clk);
        check_value("ifu readys and response valids",
                    32'({ar_ready[0], aw_ready[0], w_ready[0], b_valid[0], r_valid[0]}), 32'h0);
        check_value("lsu readys and response valids",
                    32'({ar_ready[1], aw_ready[1], w_ready[1], b_valid[1], r_valid[1]}), 32'h0);

        i = 0;
        while (i < NUM_LINES) begin
            grp      = pat[i*FIELDS];
            lsu_busy = 1'b0;
            j        = i;
            while (j < NUM_LINES && pat[j*FIELDS] == grp) begin
                if (pat[j*FIELDS+1] == 32'd1) begin
                    lsu_busy = 1'b1;
                end
                j = j + 1;
            end
            @(posedge clk);
            #2;
            // lines of one group start in the same cycle
            if (j - i == 2) begin
                fork
                    run_xfer(i);
                    run_xfer(i + 1);
                join
            end else begin
                run_xfer(i);
            end
            i = j;
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* verif/mem_patterns.txt */
// grp mgr op addr wdata strb rdata resp
// mgr 0 ifu or 1 lsu, op 0 read or 1 write, resp 0 OKAY or 2 SLVERR
00 1 1 00000000 11223344 f 00000000 0
01 1 1 00000004 aabbccdd f 00000000 0
02 1 1 00000004 00000055 1 00000000 0
03 1 1 00000004 66000000 8 00000000 0
04 1 0 00000004 00000000 0 66bbcc55 0
05 1 1 00000008 deadbeef f 00000000 0
05 0 0 00000000 00000000 0 11223344 0
06 1 0 00000004 00000000 0 66bbcc55 0
06 0 0 00000008 00000000 0 deadbeef 0
07 1 0 00000100 00000000 0 00000000 2
08 1 1 000001fc 12345678 f 00000000 2
08 0 1 00000100 ffffffff f 00000000 2
09 0 0 00000000 00000000 0 11223344 0
0a 0 1 0000000c cafef00d f 00000000 0
0b 1 0 0000000c 00000000 0 cafef00d 0

/* mem_subsystem.f */
+incdir+include
src/axi_lite_pkg.sv
src/mem_map_pkg.sv
src/axi_lite_if.sv
src/axi_lite_arbiter.sv
src/axi_lite_sram.sv
src/mem_subsystem.sv
verif/mem_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= mem_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) include/axi_lite_config.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
